// ==== hdl/mem_geom_pkg.sv ====
package mem_geom_pkg;

  // Operand matrices are square and stored row-major
  localparam int dim = 4;

  // Row or column index into one matrix
  localparam int idx_width = 2;

  // Elements per matrix, one memory word each
  localparam int depth = dim * dim;

  // Flat address, row * dim + col
  localparam int addr_width = 4;

  // Unsigned operand element
  localparam int elem_width = 16;

endpackage

// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

  typedef enum logic [1:0] {
    op_nop  = 2'd0,
    op_load = 2'd1,
    op_dot  = 2'd2
  } opcode_t;

  // Load view, target 0 selects A and 1 selects B
  typedef struct packed {
    opcode_t                                opcode;
    logic                                   target;
    logic [mem_geom_pkg::idx_width-1:0]     row;
    logic [mem_geom_pkg::idx_width-1:0]     col;
    logic [8:0]                             pad;
    logic [mem_geom_pkg::elem_width-1:0]    data;
  } load_fields_t;

  // Dot view, row of A against column of B
  typedef struct packed {
    opcode_t                                opcode;
    logic                                   pad_hi;
    logic [mem_geom_pkg::idx_width-1:0]     row;
    logic [mem_geom_pkg::idx_width-1:0]     col;
    logic [24:0]                            pad_lo;
  } dot_fields_t;

  // Opcode occupies bits 31:30 in both views
  typedef union packed {
    load_fields_t load;
    dot_fields_t  dot;
  } cmd_word_t;

  // Four 32-bit products need two extra bits
  localparam int acc_width = 34;

  // Result buffer depth on the consumer side
  localparam int result_credits = 2;
  localparam int credit_width = $clog2(result_credits + 1);

endpackage

// ==== hdl/dual_port_mem_d1.sv ====
`timescale 1ns/1ps

module dual_port_mem_d1 (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                read_en,
  input  logic [mem_geom_pkg::addr_width-1:0] addr0_r,
  output logic [mem_geom_pkg::elem_width-1:0] read_data,

  input  logic                                write_en,
  input  logic [mem_geom_pkg::elem_width-1:0] write_data,
  input  logic [mem_geom_pkg::addr_width-1:0] addr0_w
);

  logic [mem_geom_pkg::elem_width-1:0] mem [mem_geom_pkg::depth];

  // Registered read that holds between reads
  always_ff @(posedge clk) begin
    if (reset) begin
      read_data <= '0;
    end else if (read_en) begin
      read_data <= mem[addr0_r];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset && write_en) begin
      mem[addr0_w] <= write_data;
    end
  end

  // Enables must stay quiet through reset
  a_no_access_in_reset: assert property (
    @(posedge clk) reset && $past(reset) |-> !read_en && !write_en
  ) else $error("dual_port_mem_d1: access during reset");

  a_read_addr_known: assert property (
    @(posedge clk) disable iff (reset)
    read_en |-> !$isunknown(addr0_r)
  ) else $error("dual_port_mem_d1: unknown read address %h", addr0_r);

  a_write_addr_known: assert property (
    @(posedge clk) disable iff (reset)
    write_en |-> !$isunknown(addr0_w)
  ) else $error("dual_port_mem_d1: unknown write address %h", addr0_w);

endmodule

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch #(
  parameter bit col_walk = 1'b0
) (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                load_en,
  input  logic [mem_geom_pkg::addr_width-1:0] load_addr,
  input  logic [mem_geom_pkg::elem_width-1:0] load_data,

  input  logic                                start,
  input  logic [mem_geom_pkg::idx_width-1:0]  run_row,
  input  logic [mem_geom_pkg::idx_width-1:0]  run_col,

  output logic                                elem_valid,
  output logic [mem_geom_pkg::elem_width-1:0] elem_data
);

  logic                                running;
  logic [mem_geom_pkg::idx_width-1:0]  step;
  logic [mem_geom_pkg::idx_width-1:0]  walk_idx;
  logic [mem_geom_pkg::idx_width-1:0]  rd_row;
  logic [mem_geom_pkg::idx_width-1:0]  rd_col;
  logic [mem_geom_pkg::addr_width-1:0] rd_addr;

  // Walk state, one read per cycle for dim cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      step    <= '0;
    end else if (start) begin
      running <= 1'b1;
      step    <= '0;
    end else if (running) begin
      step <= step + 1'b1;
      if (step == mem_geom_pkg::idx_width'(mem_geom_pkg::dim - 1)) begin
        running <= 1'b0;
      end
    end
  end

  // Fixed index of the walk, captured at start
  always_ff @(posedge clk) begin
    if (start) begin
      walk_idx <= col_walk ? run_col : run_row;
    end
  end

  assign rd_row  = col_walk ? step : walk_idx;
  assign rd_col  = col_walk ? walk_idx : step;
  assign rd_addr = mem_geom_pkg::addr_width'(rd_row * mem_geom_pkg::dim + rd_col);

  // Read data lands one cycle after the enable
  always_ff @(posedge clk) begin
    if (reset) begin
      elem_valid <= 1'b0;
    end else begin
      elem_valid <= running;
    end
  end

  dual_port_mem_d1 u_mem (
    .clk        (clk),
    .reset      (reset),
    .read_en    (running),
    .addr0_r    (rd_addr),
    .read_data  (elem_data),
    .write_en   (load_en),
    .write_data (load_data),
    .addr0_w    (load_addr)
  );

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (reset)
    start |-> !running
  ) else $error("operand_fetch: start during a running walk");

endmodule

// ==== hdl/dot_accumulate.sv ====
`timescale 1ns/1ps

module dot_accumulate (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                a_valid,
  input  logic [mem_geom_pkg::elem_width-1:0] a_data,
  input  logic                                b_valid,
  input  logic [mem_geom_pkg::elem_width-1:0] b_data,

  input  logic                                credit_return,
  output logic                                result_valid,
  output logic [cmd_pkg::acc_width-1:0]       result_data,
  output logic                                done
);

  logic [2*mem_geom_pkg::elem_width-1:0]  product;
  logic [cmd_pkg::acc_width-1:0]          acc;
  logic [cmd_pkg::acc_width-1:0]          acc_next;
  logic [mem_geom_pkg::idx_width-1:0]     elem_cnt;
  logic                                   pending;
  logic                                   issue;
  logic [cmd_pkg::credit_width-1:0]       credit_count;

  assign product  = a_data * b_data;
  // First element of a run starts a fresh sum
  assign acc_next = (elem_cnt == '0 ? '0 : acc) + product;

  always_ff @(posedge clk) begin
    if (reset) begin
      elem_cnt <= '0;
    end else if (a_valid) begin
      elem_cnt <= elem_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (a_valid) begin
      acc <= acc_next;
    end
    if (a_valid && elem_cnt == mem_geom_pkg::idx_width'(mem_geom_pkg::dim - 1)) begin
      result_data <= acc_next;
    end
  end

  assign issue = pending && credit_count != '0;

  // Pending result waits here until a credit is free
  always_ff @(posedge clk) begin
    if (reset) begin
      pending      <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue;
      if (a_valid && elem_cnt == mem_geom_pkg::idx_width'(mem_geom_pkg::dim - 1)) begin
        pending <= 1'b1;
      end else if (issue) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_count <= cmd_pkg::credit_width'(cmd_pkg::result_credits);
    end else begin
      case ({issue, credit_return})
        2'b10:   credit_count <= credit_count - 1'b1;
        2'b01:   credit_count <= credit_count + 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

  assign done = result_valid;

  // Both fetch units run in lockstep
  a_valid_lockstep: assert property (
    @(posedge clk) disable iff (reset) a_valid == b_valid
  ) else $error("dot_accumulate: a_valid and b_valid differ");

  a_credit_bound: assert property (
    @(posedge clk) disable iff (reset) credit_count <= cmd_pkg::result_credits
  ) else $error("dot_accumulate: credit count %0d above limit", credit_count);

  a_no_excess_return: assert property (
    @(posedge clk) disable iff (reset)
    credit_return |-> credit_count < cmd_pkg::result_credits
  ) else $error("dot_accumulate: credit returned at full credit");

endmodule

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                cmd_valid,
  input  cmd_pkg::cmd_word_t                  cmd_word,
  output logic                                cmd_ready,

  input  logic                                done,

  output logic                                a_load_en,
  output logic                                b_load_en,
  output logic [mem_geom_pkg::addr_width-1:0] load_addr,
  output logic [mem_geom_pkg::elem_width-1:0] load_data,

  output logic                                start,
  output logic [mem_geom_pkg::idx_width-1:0]  run_row,
  output logic [mem_geom_pkg::idx_width-1:0]  run_col
);

  logic accept;
  logic is_load;
  logic is_dot;
  logic busy;

  assign cmd_ready = !busy;
  assign accept    = cmd_valid && cmd_ready;

  // Opcode sits at the same bits in both views
  assign is_load = cmd_word.load.opcode == cmd_pkg::op_load;
  assign is_dot  = cmd_word.dot.opcode == cmd_pkg::op_dot;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_load_en <= 1'b0;
      b_load_en <= 1'b0;
      start     <= 1'b0;
      busy      <= 1'b0;
    end else begin
      a_load_en <= accept && is_load && !cmd_word.load.target;
      b_load_en <= accept && is_load && cmd_word.load.target;
      start     <= accept && is_dot;
      if (accept && is_dot) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // Load payload with a flat row-major address
  always_ff @(posedge clk) begin
    if (accept && is_load) begin
      load_addr <= mem_geom_pkg::addr_width'(cmd_word.load.row * mem_geom_pkg::dim +
                                             cmd_word.load.col);
      load_data <= cmd_word.load.data;
    end
  end

  // Run indices hold until the next dot
  always_ff @(posedge clk) begin
    if (accept && is_dot) begin
      run_row <= cmd_word.dot.row;
      run_col <= cmd_word.dot.col;
    end
  end

endmodule

// ==== hdl/dot_engine_top.sv ====
`timescale 1ns/1ps

module dot_engine_top (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          cmd_valid,
  input  cmd_pkg::cmd_word_t            cmd_word,
  output logic                          cmd_ready,

  output logic                          result_valid,
  output logic [cmd_pkg::acc_width-1:0] result_data,
  input  logic                          credit_return
);

  logic                                a_load_en;
  logic                                b_load_en;
  logic [mem_geom_pkg::addr_width-1:0] load_addr;
  logic [mem_geom_pkg::elem_width-1:0] load_data;
  logic                                start;
  logic [mem_geom_pkg::idx_width-1:0]  run_row;
  logic [mem_geom_pkg::idx_width-1:0]  run_col;
  logic                                a_elem_valid;
  logic [mem_geom_pkg::elem_width-1:0] a_elem_data;
  logic                                b_elem_valid;
  logic [mem_geom_pkg::elem_width-1:0] b_elem_data;
  logic                                done;

  cmd_decode u_cmd_decode (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word),
    .cmd_ready (cmd_ready),
    .done      (done),
    .a_load_en (a_load_en),
    .b_load_en (b_load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .start     (start),
    .run_row   (run_row),
    .run_col   (run_col)
  );

  // A walks a row
  operand_fetch #(.col_walk(1'b0)) u_fetch_a (
    .clk        (clk),
    .reset      (reset),
    .load_en    (a_load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .start      (start),
    .run_row    (run_row),
    .run_col    (run_col),
    .elem_valid (a_elem_valid),
    .elem_data  (a_elem_data)
  );

  // B walks a column
  operand_fetch #(.col_walk(1'b1)) u_fetch_b (
    .clk        (clk),
    .reset      (reset),
    .load_en    (b_load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .start      (start),
    .run_row    (run_row),
    .run_col    (run_col),
    .elem_valid (b_elem_valid),
    .elem_data  (b_elem_data)
  );

  dot_accumulate u_dot_accumulate (
    .clk           (clk),
    .reset         (reset),
    .a_valid       (a_elem_valid),
    .a_data        (a_elem_data),
    .b_valid       (b_elem_valid),
    .b_data        (b_elem_data),
    .credit_return (credit_return),
    .result_valid  (result_valid),
    .result_data   (result_data),
    .done          (done)
  );

endmodule

// ==== testbench/dot_engine_model.svh ====
// Reference copies of both operand matrices, row-major like the DUT
logic [mem_geom_pkg::elem_width-1:0] mat_a [mem_geom_pkg::dim][mem_geom_pkg::dim];
logic [mem_geom_pkg::elem_width-1:0] mat_b [mem_geom_pkg::dim][mem_geom_pkg::dim];

// Expected dot results in command order
logic [cmd_pkg::acc_width-1:0] exp_q [$];

int result_errors = 0;
int ready_errors  = 0;
int other_errors  = 0;

task automatic clear_model();
  for (int r = 0; r < mem_geom_pkg::dim; r++) begin
    for (int c = 0; c < mem_geom_pkg::dim; c++) begin
      mat_a[r][c] = '0;
      mat_b[r][c] = '0;
    end
  end
  exp_q.delete();
endtask

// Target 0 is A, 1 is B
task automatic apply_load(input logic target, input int row, input int col,
                          input logic [mem_geom_pkg::elem_width-1:0] data);
  if (target) begin
    mat_b[row][col] = data;
  end else begin
    mat_a[row][col] = data;
  end
endtask

// Row r of A against column c of B, unsigned
function automatic logic [cmd_pkg::acc_width-1:0] dot_model(input int r, input int c);
  logic [cmd_pkg::acc_width-1:0] sum;
  sum = '0;
  for (int k = 0; k < mem_geom_pkg::dim; k++) begin
    sum = sum + mat_a[r][k] * mat_b[k][c];
  end
  return sum;
endfunction

task automatic check_result(input string name, input logic [cmd_pkg::acc_width-1:0] got,
                            input logic [cmd_pkg::acc_width-1:0] exp);
  if (got !== exp) begin
    result_errors++;
    $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    ready_errors++;
    $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic report_problem(input string msg);
  other_errors++;
  $display("%s at %0t", msg, $time);
endtask

// ==== testbench/dot_engine_tb.sv ====
`timescale 1ns/1ps

module dot_engine_tb;

  localparam int clk_period     = 20;
  localparam int n_init_loads   = 2 * mem_geom_pkg::depth;
  localparam int n_dots         = 12;
  localparam int n_rounds       = 8;
  localparam int n_hold_dots    = cmd_pkg::result_credits + 1;
  localparam int n_nops         = 6;
  localparam int n_nop_dots     = 2;
  localparam int total_cmds     = n_init_loads + n_dots + 3 * n_rounds + n_hold_dots +
                                  n_nops + n_nop_dots;
  localparam int timeout_cycles = 60 * total_cmds + 200;

  logic                          clk;
  logic                          reset;
  logic                          cmd_valid;
  cmd_pkg::cmd_word_t            cmd_word;
  logic                          cmd_ready;
  logic                          result_valid;
  logic [cmd_pkg::acc_width-1:0] result_data;
  logic                          credit_return;

  int   dots_accepted = 0;
  int   results_done  = 0;
  logic result_seen   = 1'b0;
  int   held          = 0;
  bit   hold_credits  = 1'b0;

  `include "dot_engine_model.svh"

  dot_engine_top u_dot_engine_top (
    .clk           (clk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd_word      (cmd_word),
    .cmd_ready     (cmd_ready),
    .result_valid  (result_valid),
    .result_data   (result_data),
    .credit_return (credit_return)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic int rand_idx();
    return $urandom_range(mem_geom_pkg::dim - 1, 0);
  endfunction

  // Random word with the opcode and indices forced, pad bits left random
  function automatic cmd_pkg::cmd_word_t make_word(input cmd_pkg::opcode_t op,
                                                   input logic target, input int row,
                                                   input int col);
    cmd_pkg::cmd_word_t w;
    w = $urandom;
    w.load.opcode = op;
    if (op == cmd_pkg::op_load) begin
      w.load.target = target;
      w.load.row    = mem_geom_pkg::idx_width'(row);
      w.load.col    = mem_geom_pkg::idx_width'(col);
    end else if (op == cmd_pkg::op_dot) begin
      w.dot.row = mem_geom_pkg::idx_width'(row);
      w.dot.col = mem_geom_pkg::idx_width'(col);
    end
    return w;
  endfunction

  // Ready is low exactly while a dot result is owed
  task automatic next_cycle();
    @(negedge clk);
    check_ready("cmd_ready", cmd_ready, dots_accepted == results_done);
  endtask

  task automatic record_accept(input cmd_pkg::cmd_word_t w);
    case (w.load.opcode)
      cmd_pkg::op_load: apply_load(w.load.target, w.load.row, w.load.col, w.load.data);
      cmd_pkg::op_dot: begin
        exp_q.push_back(dot_model(w.dot.row, w.dot.col));
        dots_accepted++;
      end
      default: begin
      end
    endcase
  endtask

  task automatic send_cmd(input cmd_pkg::cmd_word_t w);
    cmd_word  = w;
    cmd_valid = 1'b1;
    while (!cmd_ready) begin
      next_cycle();
    end
    record_accept(w);
    next_cycle();
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (dots_accepted != results_done || held != 0) begin
      next_cycle();
    end
    repeat (2) next_cycle();
  endtask

  always @(posedge clk) begin
    if (result_seen) begin
      results_done++;
    end
  end

  // Result checker and credit consumer
  initial begin : consumer
    int   cnt;
    int   ret_delay;
    logic ret_prev;
    credit_return = 1'b0;
    ret_delay     = -1;
    forever begin
      @(negedge clk);
      result_seen = 1'b0;
      if (reset) begin
        cnt           = cmd_pkg::result_credits;
        ret_prev      = 1'b0;
        credit_return = 1'b0;
      end else begin
        if (result_valid) begin
          result_seen = 1'b1;
          held++;
          if (cnt == 0) begin
            report_problem("Result issued with no credit left");
          end
          if (exp_q.size() == 0) begin
            report_problem("Result appeared with no dot command outstanding");
          end else begin
            check_result("result_data", result_data, exp_q.pop_front());
          end
        end
        cnt = cnt - int'(result_valid) + int'(ret_prev);
        credit_return = 1'b0;
        if (held > 0 && !hold_credits) begin
          if (ret_delay < 0) begin
            ret_delay = $urandom_range(6, 0);
          end
          if (ret_delay == 0) begin
            credit_return = 1'b1;
            held--;
            ret_delay = -1;
          end else begin
            ret_delay--;
          end
        end
        ret_prev = credit_return;
      end
    end
  end

  initial begin : stimulus
    int   base;
    int   r;
    int   c;
    logic tgt;
    void'($urandom(32'hdd8b));
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_word  = '0;
    clear_model();
    repeat (5) @(negedge clk);
    reset = 1'b0;
    repeat (5) next_cycle();

    // Fill A and B, interleaved
    for (int i = 0; i < n_init_loads; i++) begin
      send_cmd(make_word(cmd_pkg::op_load, i % 2, (i / 2) / mem_geom_pkg::dim,
                         (i / 2) % mem_geom_pkg::dim));
    end
    for (int i = 0; i < n_dots; i++) begin
      send_cmd(make_word(cmd_pkg::op_dot, 1'b0, rand_idx(), rand_idx()));
    end

    // Single overwrites, then a dot that uses the new element
    for (int i = 0; i < n_rounds; i++) begin
      tgt = $urandom_range(1, 0);
      r   = rand_idx();
      c   = rand_idx();
      send_cmd(make_word(cmd_pkg::op_load, tgt, r, c));
      send_cmd(make_word(cmd_pkg::op_dot, 1'b0, rand_idx(), rand_idx()));
      if (tgt) begin
        send_cmd(make_word(cmd_pkg::op_dot, 1'b0, rand_idx(), c));
      end else begin
        send_cmd(make_word(cmd_pkg::op_dot, 1'b0, r, rand_idx()));
      end
    end

    // Consumer stops returning credits
    wait_idle();
    hold_credits = 1'b1;
    base         = results_done;
    for (int i = 0; i < n_hold_dots; i++) begin
      send_cmd(make_word(cmd_pkg::op_dot, 1'b0, rand_idx(), rand_idx()));
    end
    repeat (20) next_cycle();
    if (results_done - base != cmd_pkg::result_credits) begin
      report_problem("Wrong number of results while credits were withheld");
    end
    hold_credits = 1'b0;

    for (int i = 0; i < n_nops; i++) begin
      send_cmd(make_word(cmd_pkg::op_nop, 1'b0, 0, 0));
    end
    for (int i = 0; i < n_nop_dots; i++) begin
      send_cmd(make_word(cmd_pkg::op_dot, 1'b0, rand_idx(), rand_idx()));
    end
    wait_idle();
    repeat (10) next_cycle();
    if (exp_q.size() != 0) begin
      report_problem("Expected results were never produced");
    end

    $display("Errors: result %0d, ready %0d, other %0d",
             result_errors, ready_errors, other_errors);
    if (result_errors + ready_errors + other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+testbench
hdl/mem_geom_pkg.sv
hdl/cmd_pkg.sv
hdl/dual_port_mem_d1.sv
hdl/operand_fetch.sv
hdl/dot_accumulate.sv
hdl/cmd_decode.sv
hdl/dot_engine_top.sv
testbench/dot_engine_tb.sv
